// File: Bender.yml
package:
  name: lsu

sources:
  - target: rtl
    include_dirs:
      - verilog
    files:
      - verilog/riscv_pkg.sv
      - verilog/obi_pkg.sv
      - verilog/lsu_align.sv
      - verilog/lsu.sv
      - verilog/data_mem.sv
      - verilog/lsu_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/lsu_assert.sv
      - tb/lsu_tb.sv

// File: all.f
+incdir+verilog
verilog/riscv_pkg.sv
verilog/obi_pkg.sv
verilog/lsu_align.sv
verilog/lsu.sv
verilog/data_mem.sv
verilog/lsu_top.sv
tb/lsu_assert.sv
tb/lsu_tb.sv

// File: tb/lsu_assert.sv
`timescale 1ns/10ps

module lsu_assert (
    input logic                 CLK,
    input logic                 RSTn,
    input logic                 busy,
    input riscv_pkg::mem_ctrl_t mem_ctrl,
    input logic [31:0]          addr,
    input obi_pkg::obi_req_t    bus_req,
    input obi_pkg::obi_rsp_t    bus_rsp
);

    import riscv_pkg::*;
    import obi_pkg::*;

    int   fail_count = 0;
    logic req_on;
    logic waiting;
    logic aligned;

    assign req_on  = (bus_req.req == REQUEST);
    assign waiting = req_on && !bus_rsp.gnt; // request up, no grant yet.

    always_comb begin
        case (mem_ctrl.size)
            MEM_HALF: aligned = !addr[0];
            MEM_WORD: aligned = (addr[1:0] == 2'b00);
            default:  aligned = 1'b1;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // bus handshake
    ////////////////////////////////////////////////////////////////////////////

    stable_while_waiting: assert property (
        @(posedge CLK) disable iff (!RSTn)
        waiting |=> req_on && $stable(bus_req.we) && $stable(bus_req.be)
                    && $stable(bus_req.addr) && $stable(bus_req.wdata)
    ) else begin
        fail_count++;
        $error("request fields changed while waiting for the grant");
    end

    rvalid_after_grant: assert property (
        @(posedge CLK) disable iff (!RSTn)
        bus_rsp.rvalid |-> $past(req_on && bus_rsp.gnt)
    ) else begin
        fail_count++;
        $error("rvalid without a grant in the cycle before");
    end

    ////////////////////////////////////////////////////////////////////////////
    // control side
    ////////////////////////////////////////////////////////////////////////////

    // busy covers the whole transaction and drops with the response.
    busy_until_response: assert property (
        @(posedge CLK) disable iff (!RSTn)
        req_on && bus_rsp.gnt |=> bus_rsp.rvalid && !busy
    ) else begin
        fail_count++;
        $error("busy did not fall with the response after a grant");
    end

    aligned_access: assert property (
        @(posedge CLK) disable iff (!RSTn)
        req_on |-> aligned
    ) else begin
        fail_count++;
        $error("misaligned access on the bus");
    end

endmodule

bind lsu lsu_assert lsu_assert_i (
    .CLK      (CLK),
    .RSTn     (RSTn),
    .busy     (busy),
    .mem_ctrl (mem_ctrl),
    .addr     (addr),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp)
);

// File: tb/lsu_tb.sv
`timescale 1ns/10ps

`include "lsu_defs.svh"

module lsu_tb;

    import riscv_pkg::*;

    localparam int WORDS   = `LSU_MEM_WORDS;
    localparam int TIMEOUT = 100;

    logic        CLK;
    logic        RSTn;
    logic        data_req;
    mem_ctrl_t   mem_ctrl;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        busy;
    logic [31:0] rdata;

    logic [31:0] ref_mem [WORDS];
    int          seed;
    int unsigned cycle_cnt;
    int unsigned due_q [$];
    logic        load_q [$];
    logic [31:0] exp_q [$];
    string       name_q [$];
    logic [31:0] last_load;
    logic        hold_valid;

    lsu_top lsu_top_i (
        .CLK      (CLK),
        .RSTn     (RSTn),
        .data_req (data_req),
        .mem_ctrl (mem_ctrl),
        .addr     (addr),
        .wdata    (wdata),
        .busy     (busy),
        .rdata    (rdata)
    );

    always #20 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] expected_load(input logic [31:0] word,
                                                  input mem_size_t size,
                                                  input logic [1:0] offset,
                                                  input logic uns);
        logic [31:0] shifted;
        shifted = word >> (8 * offset);
        case (size)
            MEM_BYTE: expected_load = uns ? {24'h0, shifted[7:0]}
                                          : {{24{shifted[7]}}, shifted[7:0]};
            MEM_HALF: expected_load = uns ? {16'h0, shifted[15:0]}
                                          : {{16{shifted[15]}}, shifted[15:0]};
            default:  expected_load = word;
        endcase
    endfunction

    task automatic model_store(input logic [31:0] a, input mem_size_t size,
                               input logic [31:0] d);
        int idx;
        int off;
        idx = (a >> 2) % WORDS; // same wrap as the memory.
        off = a[1:0];
        case (size)
            MEM_BYTE: ref_mem[idx][8*off +: 8] = d[7:0];
            MEM_HALF: ref_mem[idx][8*off +: 16] = d[15:0];
            default:  ref_mem[idx] = d;
        endcase
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s expected %08h actual %08h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge CLK);
    endtask

    task automatic run_access(input string name, input logic wr, input mem_size_t size,
                              input logic uns, input logic [31:0] a, input logic [31:0] d);
        int          waited;
        logic [31:0] expected;
        mem_ctrl.mem_en      = 1'b1;
        mem_ctrl.wr          = wr;
        mem_ctrl.size        = size;
        mem_ctrl.is_unsigned = uns;
        addr                 = a;
        wdata                = d;
        data_req             = 1'b1;
        expected             = '0;
        if (wr) begin
            model_store(a, size, d);
        end else begin
            expected = expected_load(ref_mem[(a >> 2) % WORDS], size, a[1:0], uns);
        end
        @(negedge CLK);
        data_req = 1'b0;
        waited   = 0;
        while (busy && waited < TIMEOUT) begin
            @(negedge CLK);
            waited++;
        end
        if (busy) begin
            $display("%s: the unit stayed busy for more than %0d cycles", name, TIMEOUT);
            $display("TEST FAILED");
            $fatal(1);
        end
        due_q.push_back(cycle_cnt + 1); // rdata is loaded on the next edge.
        load_q.push_back(!wr);
        exp_q.push_back(expected);
        name_q.push_back(name);
        @(negedge CLK);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // compare
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge CLK) begin
        if (due_q.size() > 0 && due_q[0] == cycle_cnt) begin
            if (load_q[0]) begin
                check_value(name_q[0], exp_q[0], rdata);
                last_load  = exp_q[0];
                hold_valid = 1'b1;
            end else begin
                hold_valid = 1'b0; // a store leaves rdata undefined.
            end
            void'(due_q.pop_front());
            void'(load_q.pop_front());
            void'(exp_q.pop_front());
            void'(name_q.pop_front());
        end else if (hold_valid) begin
            check_value("rdata hold", last_load, rdata);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rnd;
        logic [31:0] a;
        logic [31:0] d;
        logic [1:0]  off;
        mem_size_t   size;
        int          waited;
        CLK        = 1'b0;
        RSTn       = 1'b0;
        data_req   = 1'b0;
        mem_ctrl   = '0;
        addr       = '0;
        wdata      = '0;
        cycle_cnt  = 0;
        last_load  = '0;
        hold_valid = 1'b0;
        seed       = 8922;
        for (int i = 0; i < WORDS; i++) begin
            ref_mem[i] = '0;
        end
        repeat (10) @(negedge CLK);
        RSTn = 1'b1;

        check_value("reset busy", 32'h0, {31'h0, busy});
        check_value("reset rdata", 32'h0, rdata);
        data_req = 1'b1; // mem_en stays low.
        repeat (5) begin
            @(negedge CLK);
            check_value("request without mem_en", 32'h0, {31'h0, busy});
        end
        data_req = 1'b0;

        for (int i = 0; i < 8; i++) begin
            run_access("word store", 1'b1, MEM_WORD, 1'b0, (i * 29 + 3) * 4,
                       32'h9E37_79B9 * (i + 1));
        end
        for (int i = 0; i < 8; i++) begin
            run_access($sformatf("word load %0d", i), 1'b0, MEM_WORD, 1'b0,
                       (i * 29 + 3) * 4, '0);
        end

        run_access("merge base", 1'b1, MEM_WORD, 1'b0, 32'h0A0, 32'h1122_3344);
        for (int i = 0; i < 4; i++) begin
            run_access("byte merge store", 1'b1, MEM_BYTE, 1'b0, 32'h0A0 + i,
                       32'hDEAD_BE10 + i);
            run_access($sformatf("byte merge %0d", i), 1'b0, MEM_WORD, 1'b0, 32'h0A0, '0);
        end
        for (int i = 0; i < 4; i += 2) begin
            run_access("half merge store", 1'b1, MEM_HALF, 1'b0, 32'h0A0 + i,
                       32'hFACE_7A00 + i);
            run_access($sformatf("half merge %0d", i), 1'b0, MEM_WORD, 1'b0, 32'h0A0, '0);
        end

        run_access("sign base", 1'b1, MEM_WORD, 1'b0, 32'h1F0, 32'h8FF0_A5C3);
        run_access("zero base", 1'b1, MEM_WORD, 1'b0, 32'h1F4, 32'h7F3C_1A55);
        for (int u = 0; u < 2; u++) begin
            for (int i = 0; i < 4; i++) begin
                run_access($sformatf("byte ext u%0d o%0d", u, i), 1'b0, MEM_BYTE, u[0],
                           32'h1F0 + i, '0);
                run_access($sformatf("byte pos u%0d o%0d", u, i), 1'b0, MEM_BYTE, u[0],
                           32'h1F4 + i, '0);
            end
            for (int i = 0; i < 4; i += 2) begin
                run_access($sformatf("half ext u%0d o%0d", u, i), 1'b0, MEM_HALF, u[0],
                           32'h1F0 + i, '0);
                run_access($sformatf("half pos u%0d o%0d", u, i), 1'b0, MEM_HALF, u[0],
                           32'h1F4 + i, '0);
            end
        end
        idle_cycles(6); // rdata must hold here.

        for (int n = 0; n < 300; n++) begin
            rnd  = $random(seed);
            size = mem_size_t'(rnd[1:0] % 3);
            off  = rnd[5:4];
            if (size == MEM_HALF) begin
                off[0] = 1'b0;
            end else if (size == MEM_WORD) begin
                off = 2'b00;
            end
            a = {22'h0, rnd[15:8], off};
            d = $random(seed);
            run_access($sformatf("random %0d", n), rnd[2], size, rnd[3], a, d);
            idle_cycles(rnd[17:16]);
        end

        waited = 0;
        while (due_q.size() > 0 && waited < TIMEOUT) begin
            @(negedge CLK);
            waited++;
        end
        if (due_q.size() != 0) begin
            $display("%0d results were never compared", due_q.size());
        end
        if (lsu_top_i.lsu_i.lsu_assert_i.fail_count != 0) begin
            $display("%0d assertion failures on the bus",
                     lsu_top_i.lsu_i.lsu_assert_i.fail_count);
        end
        if (due_q.size() != 0 || lsu_top_i.lsu_i.lsu_assert_i.fail_count != 0) begin
            $display("TEST FAILED");
            $fatal(1);
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// File: verilog/data_mem.sv
`timescale 1ns/10ps

`include "lsu_defs.svh"

module data_mem (
    input  logic              CLK,
    input  logic              RSTn,
    input  obi_pkg::obi_req_t bus_req,
    output obi_pkg::obi_rsp_t bus_rsp
);

    import riscv_pkg::*;
    import obi_pkg::*;

    localparam int WORDS = `LSU_MEM_WORDS;
    localparam int IDX_W = $clog2(WORDS);

    logic [31:0]      mem [WORDS];
    logic [IDX_W-1:0] idx;
    logic [7:0]       lfsr_q;
    logic             feedback;
    logic             grant;
    mem_word_u        cur_word;
    mem_word_u        new_word;
    mem_word_u        wr_word;
    logic             rvalid_q;
    logic [31:0]      rdata_q;

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // grant stall pattern
    ////////////////////////////////////////////////////////////////////////

    assign feedback = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]; // maximal length.

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            lfsr_q <= `LSU_STALL_SEED;
        end else begin
            lfsr_q <= {lfsr_q[6:0], feedback};
        end
    end

    assign grant = (bus_req.req == REQUEST) && lfsr_q[0];

    ////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////

    assign idx = bus_req.addr[IDX_W+1:2]; // wraps at depth.

    always_comb begin
        cur_word.word = mem[idx];
        wr_word.word  = bus_req.wdata;
        new_word      = cur_word;
        for (int i = 0; i < 4; i++) begin
            if (bus_req.be[i]) begin
                new_word.bytes[i] = wr_word.bytes[i];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (grant && bus_req.we) begin
            mem[idx] <= new_word.word;
        end
        if (grant && !bus_req.we) begin
            rdata_q <= cur_word.word;
        end
    end

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= grant; // one pulse per grant.
        end
    end

    assign bus_rsp.gnt    = lfsr_q[0];
    assign bus_rsp.rvalid = rvalid_q;
    assign bus_rsp.rdata  = rdata_q;

endmodule

// File: verilog/lsu.sv
`timescale 1ns/10ps

module lsu (
    input  logic                CLK,
    input  logic                RSTn,
    input  logic                data_req,
    input  riscv_pkg::mem_ctrl_t mem_ctrl,
    input  logic [31:0]         addr,
    input  logic [31:0]         wdata,
    output logic                busy,
    output logic [31:0]         rdata,
    output obi_pkg::obi_req_t   bus_req,
    input  obi_pkg::obi_rsp_t   bus_rsp
);

    import riscv_pkg::*;
    import obi_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_GNT,
        WAIT_VALID
    } state_t;

    state_t      state_q;
    state_t      state_d;
    logic        start;
    logic        grant;
    logic [1:0]  ld_offset_q;
    mem_size_t   ld_size_q;
    logic        ld_unsigned_q;
    logic [31:0] ld_data;
    logic [31:0] rdata_q;

    ////////////////////////////////////////////////////////////////////////
    // transaction fsm
    ////////////////////////////////////////////////////////////////////////

    assign start = mem_ctrl.mem_en && data_req;
    assign grant = (bus_req.req == REQUEST) && bus_rsp.gnt;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d     = state_q;
        busy        = 1'b0;
        bus_req.req = NOREQUEST;
        case (state_q)
            IDLE: begin
                if (start) begin
                    busy        = 1'b1;
                    bus_req.req = REQUEST;
                    state_d     = bus_rsp.gnt ? WAIT_VALID : WAIT_GNT;
                end
            end
            WAIT_GNT: begin
                busy        = 1'b1;
                bus_req.req = REQUEST;
                if (bus_rsp.gnt) begin
                    state_d = WAIT_VALID;
                end
            end
            WAIT_VALID: begin
                busy = !bus_rsp.rvalid; // drops with the response.
                if (bus_rsp.rvalid) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // lane handling and load result
    ////////////////////////////////////////////////////////////////////////

    assign bus_req.we   = mem_ctrl.wr;
    assign bus_req.addr = {addr[31:2], 2'b00};

    lsu_align lsu_align_i (
        .st_size     (mem_ctrl.size),
        .st_offset   (addr[1:0]),
        .st_data     (wdata),
        .st_word     (bus_req.wdata),
        .st_be       (bus_req.be),
        .ld_size     (ld_size_q),
        .ld_offset   (ld_offset_q),
        .ld_unsigned (ld_unsigned_q),
        .ld_raw      (bus_rsp.rdata),
        .ld_data     (ld_data)
    );

    always_ff @(posedge CLK) begin
        if (grant) begin // addr may move after this.
            ld_offset_q   <= addr[1:0];
            ld_size_q     <= mem_ctrl.size;
            ld_unsigned_q <= mem_ctrl.is_unsigned;
        end
    end

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            rdata_q <= '0;
        end else if (state_q == WAIT_VALID && bus_rsp.rvalid) begin
            rdata_q <= ld_data;
        end
    end

    assign rdata = rdata_q;

endmodule

// File: verilog/lsu_align.sv
`timescale 1ns/10ps

module lsu_align (
    input  riscv_pkg::mem_size_t st_size,
    input  logic [1:0]           st_offset,
    input  logic [31:0]          st_data,
    output logic [31:0]          st_word,
    output logic [3:0]           st_be,
    input  riscv_pkg::mem_size_t ld_size,
    input  logic [1:0]           ld_offset,
    input  logic                 ld_unsigned,
    input  logic [31:0]          ld_raw,
    output logic [31:0]          ld_data
);

    import riscv_pkg::*;

    ////////////////////////////////////////////////////////////////////////
    // store path
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        mem_word_u st_u;
        st_u.word = st_data;
        case (st_size)
            MEM_BYTE: begin
                for (int i = 0; i < 4; i++) begin
                    st_u.bytes[i] = st_data[7:0]; // every lane.
                end
                st_be = 4'b0001 << st_offset;
            end
            MEM_HALF: begin
                for (int i = 0; i < 4; i++) begin
                    st_u.bytes[i] = st_data[8*(i%2) +: 8];
                end
                st_be = st_offset[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                st_be = 4'b1111; // full word.
            end
        endcase
        st_word = st_u.word;
    end

    ////////////////////////////////////////////////////////////////////////
    // load path
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        mem_word_u   ld_u;
        logic [7:0]  ld_byte;
        logic [15:0] ld_half;
        logic        fill;
        ld_u.word = ld_raw;
        ld_byte   = ld_u.bytes[ld_offset];
        ld_half   = {ld_u.bytes[{ld_offset[1], 1'b1}], ld_u.bytes[{ld_offset[1], 1'b0}]};
        case (ld_size)
            MEM_BYTE: begin
                fill    = !ld_unsigned && ld_byte[7];
                ld_data = {{24{fill}}, ld_byte};
            end
            MEM_HALF: begin
                fill    = !ld_unsigned && ld_half[15];
                ld_data = {{16{fill}}, ld_half};
            end
            default: begin
                fill    = 1'b0;
                ld_data = ld_raw; // word passes through.
            end
        endcase
    end

endmodule

// File: verilog/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// data memory geometry
////////////////////////////////////////////////////////////////////////////

// words of 32 bits, power of two.
`define LSU_MEM_WORDS 256

////////////////////////////////////////////////////////////////////////////
// grant back-pressure
////////////////////////////////////////////////////////////////////////////

// start value of the 8-bit stall lfsr, never zero.
// the low bit of the lfsr is the grant, so an odd seed
// grants on the first cycle after reset.
`define LSU_STALL_SEED 8'hA5

`endif

// File: verilog/lsu_top.sv
`timescale 1ns/10ps

module lsu_top (
    input  logic                 CLK,
    input  logic                 RSTn,
    input  logic                 data_req,
    input  riscv_pkg::mem_ctrl_t mem_ctrl,
    input  logic [31:0]          addr,
    input  logic [31:0]          wdata,
    output logic                 busy,
    output logic [31:0]          rdata
);

    import obi_pkg::*;

    obi_req_t bus_req;
    obi_rsp_t bus_rsp;

    ////////////////////////////////////////////////////////////////////////
    // processor side
    ////////////////////////////////////////////////////////////////////////

    lsu lsu_i (
        .CLK      (CLK),
        .RSTn     (RSTn),
        .data_req (data_req),
        .mem_ctrl (mem_ctrl),
        .addr     (addr),
        .wdata    (wdata),
        .busy     (busy),
        .rdata    (rdata),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp)
    );

    ////////////////////////////////////////////////////////////////////////
    // memory side
    ////////////////////////////////////////////////////////////////////////

    data_mem data_mem_i (
        .CLK     (CLK),
        .RSTn    (RSTn),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

endmodule

// File: verilog/obi_pkg.sv
package obi_pkg;

    ////////////////////////////////////////////////////////////////////////
    // request channel
    ////////////////////////////////////////////////////////////////////////

    typedef enum logic {
        NOREQUEST = 1'b0,
        REQUEST   = 1'b1
    } obi_req_kind_t;

    typedef struct packed {
        obi_req_kind_t req;
        logic          we;
        logic [3:0]    be;    // byte enables, writes only.
        logic [31:0]   addr;  // word aligned.
        logic [31:0]   wdata; // already lane placed.
    } obi_req_t;

    ////////////////////////////////////////////////////////////////////////
    // response channel
    ////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        gnt;    // ready.
        logic        rvalid;
        logic [31:0] rdata;
    } obi_rsp_t;

endpackage

// File: verilog/riscv_pkg.sv
package riscv_pkg;

    ////////////////////////////////////////////////////////////////////////
    // access size
    ////////////////////////////////////////////////////////////////////////

    // same coding as funct3[1:0] of the load and store opcodes.
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_t;

    ////////////////////////////////////////////////////////////////////////
    // memory control word from decode
    ////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic      mem_en;      // access in this instruction.
        logic      wr;          // store when set.
        mem_size_t size;
        logic      is_unsigned; // lbu and lhu.
    } mem_ctrl_t;

    ////////////////////////////////////////////////////////////////////////
    // one data word
    ////////////////////////////////////////////////////////////////////////

    // seen as a full word or as four byte lanes, lane 0 lowest.
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } mem_word_u;

endpackage
